//--- hdl/burst_mem_consts.svh
// ********************
// Widths and depth of the burst memory bank
// Depth follows from the word address width, bursts wrap at the top
// ********************

`ifndef BURST_MEM_CONSTS_SVH
`define BURST_MEM_CONSTS_SVH

// Data path
`define BURST_MEM_DATA_W  64 // Word width in bits
`define BURST_MEM_BE_W    8  // One enable per byte

// Addressing
`define BURST_MEM_ADDR_W  6  // Word address, no byte address bits
`define BURST_MEM_DEPTH   (1 << `BURST_MEM_ADDR_W) // Words in the bank

// Burst length, 1 to 127 beats, zero is not a legal command
`define BURST_MEM_COUNT_W 7

`endif

//--- hdl/burst_mem_pkg.sv
// ********************
// Shared types of the burst memory bank
// Widths come from the constants header
// ********************

`include "burst_mem_consts.svh"

package burst_mem_pkg;

	// ********************
	// Vectors with a meaning
	// ********************
	typedef logic [`BURST_MEM_DATA_W-1:0]  data_t;  // One stored word, also a bit mask
	typedef logic [`BURST_MEM_BE_W-1:0]    be_t;    // Byte enables
	typedef logic [`BURST_MEM_ADDR_W-1:0]  addr_t;  // Word address
	typedef logic [`BURST_MEM_COUNT_W-1:0] count_t; // Beats requested or left

	// ********************
	// Sequencer FSM
	// ********************
	typedef enum logic [1:0] {
		SEQ_IDLE        = 2'd0, // Ready for a command
		SEQ_READ_BURST  = 2'd1, // Streaming read beats, waitrequest high
		SEQ_WRITE_BURST = 2'd2  // Waiting for the remaining write words
	} seq_state_t;

endpackage

//--- hdl/mem_access_if.sv
// ********************
// One word access per cycle, sequencer to word store
// wr_en and rd_en are single-cycle pulses, never both high
// ********************

`timescale 1ns/1ps

interface mem_access_if;
	import burst_mem_pkg::*;

	logic  wr_en; // Store one word this edge
	logic  rd_en; // Read beat, word at addr goes to the output side
	addr_t addr;  // Word being accessed
	data_t wdata; // Write data, only meaningful with wr_en
	data_t mask;  // Bit mask, one where wdata replaces the old word

	// Sequencer side drives everything
	modport seq (
		output wr_en, rd_en, addr, wdata, mask
	);

	// Store side only listens
	modport store (
		input wr_en, rd_en, addr, wdata, mask
	);

endinterface

//--- hdl/byte_mask_port.sv
// ********************
// Byte enables to bit mask, held for the length of a write burst
// Later words of a burst use the first word's byte enables
// ********************

`timescale 1ns/1ps
`include "burst_mem_consts.svh"

module byte_mask_port (
	input  logic                 DDR4_USERCLK,
	input  logic                 reset,
	input  burst_mem_pkg::be_t   byteenable, // Live enables from the host
	input  logic                 start,      // Write command accepted this edge
	input  logic                 busy,       // Burst in progress
	output burst_mem_pkg::data_t mask
);
	import burst_mem_pkg::*;

	localparam int BYTE_W = `BURST_MEM_DATA_W / `BURST_MEM_BE_W; // Bits per enable

	data_t live_mask;   // Straight expansion of byteenable
	data_t held_mask_q; // Mask captured at burst start

	// ********************
	// Expansion
	// ********************
	genvar b;
	generate
		for (b = 0; b < `BURST_MEM_BE_W; b = b + 1) begin : g_byte
			assign live_mask[b*BYTE_W +: BYTE_W] = {BYTE_W{byteenable[b]}}; // Copy enable to its byte
		end
	endgenerate

	// Capture on the command edge, the first word uses the live mask anyway
	always_ff @(posedge DDR4_USERCLK) begin
		if (reset) begin
			held_mask_q <= '0;
		end else if (start) begin
			held_mask_q <= live_mask;
		end
	end

	// Idle cycles see the host enables directly
	assign mask = busy ? held_mask_q : live_mask;

endmodule

//--- hdl/burst_sequencer.sv
// ********************
// Burst FSM, takes commands only when idle, read wins over write
// Strobes during a burst are ignored, burstcount of zero is illegal
// Addresses wrap to word 0 past the top of the bank
// ********************

`timescale 1ns/1ps

module burst_sequencer (
	input  logic                  DDR4_USERCLK,
	input  logic                  reset,
	input  logic                  read,
	input  logic                  write,
	input  burst_mem_pkg::addr_t  address,
	input  burst_mem_pkg::count_t burstcount,
	input  burst_mem_pkg::data_t  writedata,
	input  burst_mem_pkg::data_t  mask,        // From the byte mask side
	output logic                  start,       // Write command taken
	output logic                  busy,        // Not idle
	output logic                  waitrequest,
	mem_access_if.seq             mem
);
	import burst_mem_pkg::*;

	seq_state_t state_q;      // FSM state
	count_t     beats_q;      // Beats still to go
	addr_t      burst_addr_q; // Next word of the burst
	logic       idle;
	logic       take_read;    // Read command accepted this edge
	logic       take_write;   // Write command accepted this edge
	logic       beat_last;    // Current beat is the final one

	// ********************
	// Command decode
	// ********************
	assign idle       = (state_q == SEQ_IDLE);
	assign take_read  = idle & read;
	assign take_write = idle & write & ~read; // Read has priority
	assign beat_last  = (beats_q == count_t'(1));

	assign start       = take_write;
	assign busy        = ~idle;
	assign waitrequest = (state_q == SEQ_READ_BURST); // Only reads hold off the host

	// ********************
	// Access to the store
	// ********************
	always_comb begin
		mem.rd_en = 1'b0;
		mem.wr_en = 1'b0;
		mem.addr  = burst_addr_q;
		mem.wdata = writedata; // Host data goes straight through
		mem.mask  = mask;
		case (state_q)
			SEQ_IDLE: begin
				// First write word lands on the command edge
				mem.wr_en = take_write;
				mem.addr  = address;
			end
			SEQ_READ_BURST: begin
				mem.rd_en = 1'b1; // One beat every cycle
			end
			SEQ_WRITE_BURST: begin
				mem.wr_en = write; // Write low stalls the burst
			end
			default: begin
				mem.rd_en = 1'b0;
			end
		endcase
	end

	// ********************
	// State, counter, address
	// ********************
	always_ff @(posedge DDR4_USERCLK) begin
		if (reset) begin
			state_q      <= SEQ_IDLE;
			beats_q      <= '0;
			burst_addr_q <= '0;
		end else begin
			case (state_q)
				SEQ_IDLE: begin
					if (take_read) begin
						state_q      <= SEQ_READ_BURST;
						beats_q      <= burstcount;
						burst_addr_q <= address;
					end else if (take_write) begin
						// One word already stored, count the rest
						beats_q      <= burstcount - count_t'(1);
						burst_addr_q <= address + addr_t'(1);
						if (burstcount != count_t'(1)) begin
							state_q <= SEQ_WRITE_BURST;
						end
					end
				end
				SEQ_READ_BURST: begin
					beats_q      <= beats_q - count_t'(1);
					burst_addr_q <= burst_addr_q + addr_t'(1); // Wraps at the top
					if (beat_last) begin
						state_q <= SEQ_IDLE;
					end
				end
				SEQ_WRITE_BURST: begin
					if (write) begin
						beats_q      <= beats_q - count_t'(1);
						burst_addr_q <= burst_addr_q + addr_t'(1);
						if (beat_last) begin
							state_q <= SEQ_IDLE;
						end
					end
				end
				default: begin
					state_q <= SEQ_IDLE; // Recover from an illegal encoding
				end
			endcase
		end
	end

endmodule

//--- hdl/word_store.sv
// ********************
// Word array with a written flag per word
// Never-written words count as zero in the merge
// Read port is combinational at mem.addr
// ********************

`timescale 1ns/1ps
`include "burst_mem_consts.svh"

module word_store (
	input  logic                 DDR4_USERCLK,
	input  logic                 reset,
	mem_access_if.store          mem,
	output burst_mem_pkg::data_t rdata,  // Stored word at mem.addr
	output logic                 written // Word at mem.addr has been written
);
	import burst_mem_pkg::*;

	data_t                       mem_q [`BURST_MEM_DEPTH]; // Payload, no reset
	logic [`BURST_MEM_DEPTH-1:0] written_q;               // Cleared by reset
	data_t                       old_word;                // Current contents as the merge sees them
	data_t                       merged;

	// ********************
	// Merge
	// ********************
	assign old_word = written_q[mem.addr] ? mem_q[mem.addr] : '0;
	assign merged   = (old_word & ~mem.mask) | (mem.wdata & mem.mask); // New bytes under the mask

	always_ff @(posedge DDR4_USERCLK) begin
		if (mem.wr_en) begin
			mem_q[mem.addr] <= merged;
		end
	end

	// Flags mark words that hold real data
	always_ff @(posedge DDR4_USERCLK) begin
		if (reset) begin
			written_q <= '0;
		end else if (mem.wr_en) begin
			written_q[mem.addr] <= 1'b1;
		end
	end

	// ********************
	// Read side
	// ********************
	assign rdata   = mem_q[mem.addr];
	assign written = written_q[mem.addr];

endmodule

//--- hdl/read_return.sv
// ********************
// Registers each read beat for the host
// Unwritten words go out as zero
// ********************

`timescale 1ns/1ps

module read_return (
	input  logic                 DDR4_USERCLK,
	input  logic                 reset,
	input  logic                 rd_en,   // Read beat from the sequencer
	input  burst_mem_pkg::data_t rdata,   // Word from the store
	input  logic                 written, // Flag of that word
	output burst_mem_pkg::data_t readdata,
	output logic                 readdatavalid
);
	import burst_mem_pkg::*;

	data_t beat_word; // Word after the zero rule

	assign beat_word = written ? rdata : '0;

	always_ff @(posedge DDR4_USERCLK) begin
		if (reset) begin
			readdata      <= '0;
			readdatavalid <= 1'b0;
		end else begin
			readdatavalid <= rd_en; // One cycle behind the beat
			if (rd_en) begin
				readdata <= beat_word; // Holds between beats
			end
		end
	end

endmodule

//--- hdl/burst_mem_top.sv
// ********************
// One bank of burst memory, 64 words of 64 bits
// Command taken only while waitrequest is low and no write burst is open
// readdatavalid follows each read beat by one cycle
// ********************

`timescale 1ns/1ps

module burst_mem_top (
	input  logic                  DDR4_USERCLK,
	input  logic                  reset,
	// Host commands
	input  logic                  read,
	input  logic                  write,
	input  burst_mem_pkg::addr_t  address,
	input  burst_mem_pkg::count_t burstcount,
	input  burst_mem_pkg::data_t  writedata,
	input  burst_mem_pkg::be_t    byteenable,
	// Host responses
	output logic                  waitrequest,
	output burst_mem_pkg::data_t  readdata,
	output logic                  readdatavalid
);
	import burst_mem_pkg::*;

	data_t mask;    // Bit mask for the current write word
	logic  start;   // Write command taken
	logic  busy;    // Burst in progress
	data_t rdata;   // Store word at the access address
	logic  written; // Its written flag

	mem_access_if mem_if ();

	// ********************
	// Input side
	// ********************
	byte_mask_port i_byte_mask_port (
		.DDR4_USERCLK (DDR4_USERCLK),
		.reset        (reset),
		.byteenable   (byteenable),
		.start        (start),
		.busy         (busy),
		.mask         (mask)
	);

	burst_sequencer i_burst_sequencer (
		.DDR4_USERCLK (DDR4_USERCLK),
		.reset        (reset),
		.read         (read),
		.write        (write),
		.address      (address),
		.burstcount   (burstcount),
		.writedata    (writedata),
		.mask         (mask),
		.start        (start),
		.busy         (busy),
		.waitrequest  (waitrequest),
		.mem          (mem_if.seq)
	);

	// ********************
	// Storage and output side
	// ********************
	word_store i_word_store (
		.DDR4_USERCLK (DDR4_USERCLK),
		.reset        (reset),
		.mem          (mem_if.store),
		.rdata        (rdata),
		.written      (written)
	);

	read_return i_read_return (
		.DDR4_USERCLK  (DDR4_USERCLK),
		.reset         (reset),
		.rd_en         (mem_if.rd_en), // Beat pulse taken off the access bus
		.rdata         (rdata),
		.written       (written),
		.readdata      (readdata),
		.readdatavalid (readdatavalid)
	);

endmodule

//--- bench/burst_mem_tb.sv
// ********************
// Directed testbench for one burst memory bank
// Inputs change on the falling edge, outputs are sampled there too
// Expected words come from a reference array with written flags
// ********************

`timescale 1ns/1ps
`include "burst_mem_consts.svh"

module burst_mem_tb;
	import burst_mem_pkg::*;

	localparam int BYTE_W    = `BURST_MEM_DATA_W / `BURST_MEM_BE_W;
	localparam int BEAT_SUM  = 46 + 20 * 8; // Directed beats plus worst case random beats
	localparam int BURST_NUM = 11 + 20;     // Directed bursts plus random bursts
	localparam int WATCHDOG_CYCLES = 2 * (BEAT_SUM + 4 * BURST_NUM) + 10;

	logic   DDR4_USERCLK;
	logic   reset;
	logic   read;
	logic   write;
	addr_t  address;
	count_t burstcount;
	data_t  writedata;
	be_t    byteenable;
	logic   waitrequest;
	data_t  readdata;
	logic   readdatavalid;

	data_t       ref_mem     [0:`BURST_MEM_DEPTH-1]; // Model contents
	logic        ref_written [0:`BURST_MEM_DEPTH-1]; // Model written flags
	data_t       wbuf        [0:127];                // Words for the next write burst
	logic [31:0] lfsr_q;
	int          errors;
	int          checks;

	burst_mem_top i_burst_mem_top (
		.DDR4_USERCLK  (DDR4_USERCLK),
		.reset         (reset),
		.read          (read),
		.write         (write),
		.address       (address),
		.burstcount    (burstcount),
		.writedata     (writedata),
		.byteenable    (byteenable),
		.waitrequest   (waitrequest),
		.readdata      (readdata),
		.readdatavalid (readdatavalid)
	);

	// 40 ns period
	initial begin
		DDR4_USERCLK = 1'b0;
		forever #20 DDR4_USERCLK = ~DDR4_USERCLK;
	end

	// Ends a hung run
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge DDR4_USERCLK);
		$display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("Done: errors found");
		$finish;
	end

	// ********************
	// Helpers
	// ********************
	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [63:0] lfsr_take(input int nbits);
		logic [63:0] v;
		logic        fb;
		int          i;
		v = '0;
		for (i = 0; i < nbits; i++) begin
			fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			v      = {v[62:0], fb};
		end
		return v;
	endfunction

	function automatic data_t expand_be(input be_t be);
		data_t m;
		int    b;
		for (b = 0; b < `BURST_MEM_BE_W; b++) begin
			m[b*BYTE_W +: BYTE_W] = {BYTE_W{be[b]}}; // Whole byte follows its enable
		end
		return m;
	endfunction

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	// ********************
	// Bus tasks, called on a falling edge
	// ********************
	// Words come from wbuf, later words keep the first word's enables
	task automatic write_burst(input addr_t a, input int n, input be_t be,
		input int stall_at, input int stall_len);
		data_t m;
		data_t old_word;
		addr_t wa;
		int    i;
		m = expand_be(be);
		for (i = 0; i < n; i++) begin
			if (i == stall_at) begin
				write = 1'b0; // Host pauses mid-burst
				repeat (stall_len) begin
					@(negedge DDR4_USERCLK);
					check_value("waitrequest", waitrequest, 64'd0);
				end
			end
			write      = 1'b1;
			address    = a;
			burstcount = count_t'(n);
			writedata  = wbuf[i];
			byteenable = (i == 0) ? be : ~be; // Later enables must be ignored
			@(negedge DDR4_USERCLK);
			check_value("waitrequest", waitrequest, 64'd0);
			wa       = a + addr_t'(i);
			old_word = ref_written[wa] ? ref_mem[wa] : '0;
			ref_mem[wa]     = (old_word & ~m) | (wbuf[i] & m);
			ref_written[wa] = 1'b1;
		end
		write      = 1'b0;
		byteenable = be;
	endtask

	// Optional stray write strobe at loop cycle stray_at, -1 for none
	task automatic read_burst(input addr_t a, input int n, input int stray_at);
		addr_t ra;
		data_t exp_word;
		int    got;
		int    cycles;
		read       = 1'b1;
		address    = a;
		burstcount = count_t'(n);
		@(negedge DDR4_USERCLK); // Command edge passed
		read   = 1'b0;
		got    = 0;
		cycles = 0;
		while (got < n && cycles < n + 2) begin
			// High from the cycle after the command through the last beat
			check_value("waitrequest", waitrequest, (cycles < n) ? 64'd1 : 64'd0);
			if (readdatavalid) begin
				check_value("readdatavalid cycle", cycles, got + 1); // Back to back, one cycle late
				ra       = a + addr_t'(got);
				exp_word = ref_written[ra] ? ref_mem[ra] : '0;
				check_value("readdata", readdata, exp_word);
				got++;
			end
			if (cycles == stray_at) begin
				write      = 1'b1;
				address    = a + addr_t'(3);
				burstcount = count_t'(1);
				writedata  = 64'hdead_beef_0bad_f00d;
				byteenable = '1;
			end else if (cycles == stray_at + 1) begin
				write = 1'b0;
			end
			@(negedge DDR4_USERCLK);
			cycles++;
		end
		if (got < n) begin
			errors++;
			$display("read burst at address %0d returned only %0d of %0d words in time", a, got, n);
		end
		check_value("readdatavalid", readdatavalid, 64'd0);
		check_value("waitrequest", waitrequest, 64'd0);
	endtask

	// ********************
	// Directed tests
	// ********************
	task automatic test_reset_read();
		int e0;
		e0 = errors;
		check_value("readdatavalid", readdatavalid, 64'd0);
		check_value("waitrequest", waitrequest, 64'd0);
		check_value("readdata", readdata, 64'd0);
		read_burst(addr_t'(8), 4, -1); // Nothing written yet, all zero
		report_test("reset and unwritten read", e0);
	endtask

	task automatic test_single_word();
		int e0;
		e0 = errors;
		wbuf[0] = 64'h0123_4567_89ab_cdef;
		write_burst(addr_t'(5), 1, 8'hff, -1, 0);
		read_burst(addr_t'(5), 1, -1);
		report_test("single word", e0);
	endtask

	task automatic test_partial_merge();
		int e0;
		int i;
		e0 = errors;
		for (i = 0; i < 4; i++) begin
			wbuf[i] = 64'h1111_1111_1111_1111 * (i + 1); // Full words first
		end
		write_burst(addr_t'(16), 4, 8'hff, -1, 0);
		for (i = 0; i < 4; i++) begin
			wbuf[i] = 64'hffee_ddcc_bbaa_9988 ^ i;
		end
		write_burst(addr_t'(16), 4, 8'h5a, 2, 2); // Stall two cycles before word 2
		read_burst(addr_t'(16), 4, -1);
		report_test("partial merge with stall", e0);
	endtask

	task automatic test_read_ignores_write();
		int e0;
		e0 = errors;
		read_burst(addr_t'(16), 8, 2); // Stray strobe while busy
		read_burst(addr_t'(16), 8, -1);
		report_test("write during read burst", e0);
	endtask

	task automatic test_wrap();
		int e0;
		int i;
		e0 = errors;
		for (i = 0; i < 4; i++) begin
			wbuf[i] = 64'hcafe_0000_0000_0000 | i;
		end
		write_burst(addr_t'(62), 4, 8'hff, -1, 0);
		read_burst(addr_t'(62), 4, -1);
		read_burst(addr_t'(0), 2, -1); // Wrapped words land at 0 and 1
		report_test("address wrap", e0);
	endtask

	task automatic test_random_bursts();
		int    e0;
		int    k;
		int    i;
		int    n;
		addr_t a;
		be_t   be;
		logic  dir;
		e0 = errors;
		for (k = 0; k < 20; k++) begin
			a   = addr_t'(lfsr_take(`BURST_MEM_ADDR_W));
			n   = int'(lfsr_take(3)) + 1; // 1 to 8 words
			be  = be_t'(lfsr_take(`BURST_MEM_BE_W));
			dir = (lfsr_take(1) != 64'd0);
			if (dir) begin
				for (i = 0; i < n; i++) begin
					wbuf[i] = lfsr_take(64);
				end
				write_burst(a, n, be, -1, 0);
			end else begin
				read_burst(a, n, -1);
			end
		end
		report_test("random bursts", e0);
	endtask

	// ********************
	// Main sequence
	// ********************
	initial begin
		reset      = 1'b1;
		read       = 1'b0;
		write      = 1'b0;
		address    = '0;
		burstcount = '0;
		writedata  = '0;
		byteenable = '0;
		lfsr_q     = 32'h695d;
		errors     = 0;
		checks     = 0;
		for (int i = 0; i < `BURST_MEM_DEPTH; i++) begin
			ref_mem[i]     = '0;
			ref_written[i] = 1'b0;
		end
		repeat (3) @(posedge DDR4_USERCLK);
		@(negedge DDR4_USERCLK);
		reset = 1'b0;

		test_reset_read();
		test_single_word();
		test_partial_merge();
		test_read_ignores_write();
		test_wrap();
		test_random_bursts();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- burst_mem.f
+incdir+hdl
hdl/burst_mem_pkg.sv
hdl/mem_access_if.sv
hdl/byte_mask_port.sv
hdl/burst_sequencer.sv
hdl/word_store.sv
hdl/read_return.sv
hdl/burst_mem_top.sv
bench/burst_mem_tb.sv
